// ==== sources.f ====
+incdir+source
source/uio_pkg.sv
source/ps2_pkg.sv
source/uio_cmd_fsm.sv
source/input_regs.sv
source/ps2_clk_div.sv
source/ps2_byte_fifo.sv
source/ps2_serializer.sv
source/hps_link_top.sv
testbench/hps_link_properties.sv
testbench/hps_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module hps_link_tb -o hps_link_sim

./obj_dir/hps_link_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1

// ==== testbench/hps_link_tb.sv ====
`include "hps_link_settings.svh"

module hps_link_tb;
	import uio_pkg::*;

	localparam int CYCLE_LIMIT = 4000;
	localparam int PS2_PERIOD  = 2 * (`HPS_PS2_DIV + 1);

	logic               clk_sys;
	logic               reset;
	logic               io_enable;
	logic               io_strobe;
	logic [15:0]        io_din;
	logic [15:0]        io_dout;
	logic [2:0]         kbd_led_status;
	logic [2:0]         kbd_led_use;
	logic [1:0]         buttons;
	logic               forced_scandoubler;
	logic [31:0]        joystick_0;
	logic [31:0]        joystick_1;
	logic [63:0]        status;
	ps2_pkg::ps2_line_t ps2_kbd;
	ps2_pkg::ps2_line_t ps2_mouse;

	integer      seed = 28129;
	int          errors = 0;
	int          tests_bad = 0;
	int          cycle_cnt = 0;
	logic [15:0] words [8];
	logic [10:0] kbd_frames [$];
	logic [10:0] mouse_frames [$];
	logic [10:0] kbd_shift;
	logic [10:0] mouse_shift;
	int          kbd_bits = 0;
	int          mouse_bits = 0;

	hps_link_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
		$display("test failed");
		$finish;
	end

	////////////////////
	// ps2 receivers sample dat on the falling clk
	// start bit ends up in bit 0
	always @(negedge ps2_kbd.clk) begin
		kbd_shift = {ps2_kbd.dat, kbd_shift[10:1]};
		kbd_bits++;
		if (kbd_bits == 11) begin
			kbd_frames.push_back(kbd_shift);
			kbd_bits = 0;
		end
	end

	always @(negedge ps2_mouse.clk) begin
		mouse_shift = {ps2_mouse.dat, mouse_shift[10:1]};
		mouse_bits++;
		if (mouse_bits == 11) begin
			mouse_frames.push_back(mouse_shift);
			mouse_bits = 0;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_frame(input string port, input logic [10:0] f, input logic [7:0] b);
		check_value({port, " start"}, 64'(f[0]), 64'h0);
		check_value({port, " data"}, 64'(f[8:1]), 64'(b));
		check_value({port, " parity"}, 64'(f[9]), 64'(~^b));
		check_value({port, " stop"}, 64'(f[10]), 64'h1);
	endtask

	task automatic report(input string name, input int mark);
		if (errors == mark) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d mismatches", name, errors - mark);
			tests_bad++;
		end
	endtask

	////////////////////
	// command strobe then n data strobes back to back
	task automatic host_frame(input logic [15:0] cmd, input int n);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		io_strobe <= 1'b1;
		io_din    <= cmd;
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			io_din <= words[i];
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		io_strobe <= 1'b0;
		io_din    <= '0;
		// registers settle two edges after the last strobe is taken
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// led readback with a gap after each data strobe
	task automatic host_read(input int n, input logic [15:0] exp);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		io_strobe <= 1'b1;
		io_din    <= CMD_KBD_LED;
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din    <= '0;
			@(posedge clk_sys);
			io_strobe <= 1'b0;
			@(negedge clk_sys);
			check_value("io_dout", 64'(io_dout), 64'(exp));
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("io_dout", 64'(io_dout), 64'h0);
	endtask

	////////////////////
	initial begin
		logic [31:0] rnd;
		logic [7:0]  kb [3];
		int          mark;

		reset          = 1'b1;
		io_enable      = 1'b0;
		io_strobe      = 1'b0;
		io_din         = '0;
		kbd_led_status = '0;
		kbd_led_use    = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;

		mark = errors;
		rnd = $random(seed);
		words[0] = rnd[15:0];
		host_frame(CMD_CFG, 1);
		check_value("buttons", 64'(buttons), 64'(rnd[1:0]));
		check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(rnd[4]));
		report("cfg word", mark);

		mark = errors;
		words[0] = 16'($random(seed));
		words[1] = 16'($random(seed));
		host_frame(CMD_JOY0, 2);
		check_value("joystick_0", 64'(joystick_0), 64'({words[1], words[0]}));
		words[0] = 16'($random(seed));
		words[1] = 16'($random(seed));
		host_frame(CMD_JOY1, 2);
		check_value("joystick_1", 64'(joystick_1), 64'({words[1], words[0]}));
		report("joysticks", mark);

		// words 5 and 6 fall past the top slice
		mark = errors;
		for (int i = 0; i < 6; i++)
			words[i] = 16'($random(seed));
		host_frame(CMD_STATUS, 6);
		check_value("status", status, {words[3], words[2], words[1], words[0]});
		report("status", mark);

		mark = errors;
		rnd = $random(seed);
		@(posedge clk_sys);
		kbd_led_status <= rnd[2:0];
		kbd_led_use    <= rnd[5:3];
		host_read(2, {8'h00, 2'b01, rnd[2], rnd[5], rnd[1], rnd[4], rnd[0], rnd[3]});
		report("led readback", mark);

		mark = errors;
		for (int i = 0; i < 3; i++) begin
			kb[i] = 8'($random(seed));
			words[i] = {8'h00, kb[i]};
		end
		host_frame(CMD_PS2_KBD, 3);
		while (kbd_frames.size() < 3)
			@(posedge clk_sys);
		for (int i = 0; i < 3; i++)
			check_frame("ps2_kbd", kbd_frames[i], kb[i]);
		while (ps2_kbd !== 2'b11)
			@(posedge clk_sys);
		assert (mouse_frames.size() == 0 && mouse_bits == 0)
		else begin
			$display("ps2_mouse sent bits during a keyboard-only test");
			errors++;
		end
		report("ps2 keyboard", mark);

		mark = errors;
		for (int i = 0; i < 3; i++)
			kb[i] = 8'($random(seed));
		words[0] = {8'h00, kb[0]};
		words[1] = {8'hFF, kb[1]};
		words[2] = {8'h00, kb[2]};
		host_frame(CMD_PS2_MOUSE, 3);
		while (mouse_frames.size() < 1)
			@(posedge clk_sys);
		while (ps2_mouse !== 2'b11)
			@(posedge clk_sys);
		// a queued byte would start within one ps2 clock
		repeat (2 * PS2_PERIOD) @(posedge clk_sys);
		check_frame("ps2_mouse", mouse_frames[0], kb[0]);
		assert (mouse_frames.size() == 1 && mouse_bits == 0
			&& kbd_frames.size() == 3 && kbd_bits == 0)
		else begin
			$display("bytes after the skip word still went out on a ps2 port");
			errors++;
		end
		report("ps2 mouse skip", mark);

		$display("summary: 6 tests, %0d with mismatches, %0d check errors, %0d property errors",
			tests_bad, errors, DUT.props.fail_count);
		if (errors == 0 && DUT.props.fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== testbench/hps_link_properties.sv ====
`include "hps_link_settings.svh"

module hps_link_properties (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   io_enable,
	input logic [`HPS_WORD_W-1:0] io_dout,
	input ps2_pkg::ps2_line_t     ps2_kbd,
	input ps2_pkg::ps2_line_t     ps2_mouse
);
	int fail_count = 0;

	////////////////////
	// a closed host port reads zero
	dout_idle: assert property (@(posedge clk_sys) !io_enable |=> io_dout == '0)
	else begin
		$error("io_dout not zero after io_enable was low");
		fail_count++;
	end

	// both ports idle straight out of reset
	lines_idle: assert property (@(posedge clk_sys)
		reset |=> (ps2_kbd == 2'b11) && (ps2_mouse == 2'b11))
	else begin
		$error("ps2 lines not idle after reset");
		fail_count++;
	end

	////////////////////
	// dat only moves while clk is high
	kbd_dat_hold: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(ps2_kbd.dat) |-> ps2_kbd.clk)
	else begin
		$error("ps2_kbd dat changed while clk was low");
		fail_count++;
	end

	mouse_dat_hold: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(ps2_mouse.dat) |-> ps2_mouse.clk)
	else begin
		$error("ps2_mouse dat changed while clk was low");
		fail_count++;
	end

endmodule

bind hps_link_top hps_link_properties props (.*);

// ==== source/hps_link_top.sv ====
`include "hps_link_settings.svh"

module hps_link_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	output logic [`HPS_WORD_W-1:0] io_dout,
	input  logic [2:0]             kbd_led_status,
	input  logic [2:0]             kbd_led_use,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output logic [63:0]            status,
	output ps2_pkg::ps2_line_t     ps2_kbd,
	output ps2_pkg::ps2_line_t     ps2_mouse
);
	import uio_pkg::*;

	uio_word_t host_word;
	logic      rise_tick;
	logic      fall_tick;

	////////////////////
	// host port
	uio_cmd_fsm host_port (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.io_enable      (io_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.kbd_led_status (kbd_led_status),
		.kbd_led_use    (kbd_led_use),
		.io_dout        (io_dout),
		.host_word      (host_word)
	);

	input_regs regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.host_word          (host_word),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	////////////////////
	// ps2 emulation, one shared clock
	ps2_clk_div ps2_clk (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.rise_tick (rise_tick),
		.fall_tick (fall_tick)
	);

	ps2_serializer #(.PORT_CMD(CMD_PS2_KBD)) kbd_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.host_word (host_word),
		.rise_tick (rise_tick),
		.fall_tick (fall_tick),
		.line      (ps2_kbd)
	);

	ps2_serializer #(.PORT_CMD(CMD_PS2_MOUSE)) mouse_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.host_word (host_word),
		.rise_tick (rise_tick),
		.fall_tick (fall_tick),
		.line      (ps2_mouse)
	);

endmodule

// ==== source/ps2_serializer.sv ====
module ps2_serializer #(
	parameter uio_pkg::uio_cmd_e PORT_CMD = uio_pkg::CMD_PS2_KBD
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  uio_pkg::uio_word_t host_word,
	input  logic               rise_tick,
	input  logic               fall_tick,
	output ps2_pkg::ps2_line_t line
);
	import ps2_pkg::*;

	ps2_tx_state_e state;
	logic          fifo_wr;
	logic          fifo_rd;
	logic          fifo_empty;
	logic [7:0]    fifo_rdata;
	logic [7:0]    shift;
	logic          parity;
	logic [2:0]    bit_cnt;

	assign fifo_wr = host_word.valid && (host_word.cmd == PORT_CMD);
	// byte leaves the queue together with the start bit
	assign fifo_rd = rise_tick && (state == IDLE) && !fifo_empty;

	ps2_byte_fifo tx_fifo (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr      (fifo_wr),
		.wdata   (host_word.data[7:0]),
		.rd      (fifo_rd),
		.rdata   (fifo_rdata),
		.empty   (fifo_empty)
	);

	////////////////////
	// shifter, odd parity starts at 1
	always_ff @(posedge clk_sys) begin
		if (fifo_rd) begin
			shift  <= fifo_rdata;
			parity <= 1'b1;
		end else if (rise_tick && ((state == START) || (state == DATA && bit_cnt != 3'd7))) begin
			shift  <= {1'b0, shift[7:1]};
			parity <= parity ^ shift[0];
		end
		if (rise_tick && (state == START))
			bit_cnt <= '0;
		else if (rise_tick && (state == DATA))
			bit_cnt <= bit_cnt + 3'd1;
	end

	////////////////////
	// line drive, dat moves only while clk is high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= IDLE;
			line.clk <= 1'b1;
			line.dat <= 1'b1;
		end else if (rise_tick) begin
			line.clk <= 1'b1;
			case (state)
				IDLE: begin
					if (!fifo_empty) begin
						line.dat <= 1'b0;
						state    <= START;
					end
				end
				START: begin
					line.dat <= shift[0];
					state    <= DATA;
				end
				DATA: begin
					if (bit_cnt == 3'd7) begin
						line.dat <= parity;
						state    <= PARITY;
					end else begin
						line.dat <= shift[0];
					end
				end
				PARITY: begin
					line.dat <= 1'b1;
					state    <= STOP;
				end
				STOP:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end else if (fall_tick && (state != IDLE)) begin
			line.clk <= 1'b0;
		end
	end

endmodule

// ==== source/ps2_byte_fifo.sv ====
`include "hps_link_settings.svh"

module ps2_byte_fifo #(
	parameter int ADDR_BITS = `HPS_FIFO_BITS
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       wr,
	input  logic [7:0] wdata,
	input  logic       rd,
	output logic [7:0] rdata,
	output logic       empty
);
	localparam int DEPTH = 1 << ADDR_BITS;

	logic [7:0]           mem [DEPTH];
	logic [ADDR_BITS-1:0] wptr;
	logic [ADDR_BITS-1:0] rptr;
	logic [ADDR_BITS:0]   count;
	logic                 full;
	logic                 do_wr;
	logic                 do_rd;

	assign full  = (count == (ADDR_BITS + 1)'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	// head byte always visible
	assign rdata = mem[rptr];

	always_ff @(posedge clk_sys) begin
		if (do_wr)
			mem[wptr] <= wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wptr <= wptr + 1'b1;
			if (do_rd)
				rptr <= rptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// ==== source/ps2_clk_div.sv ====
`include "hps_link_settings.svh"

module ps2_clk_div (
	input  logic clk_sys,
	input  logic reset,
	output logic rise_tick,
	output logic fall_tick
);
	localparam int CNT_W = $clog2(`HPS_PS2_DIV + 2);

	logic [CNT_W-1:0] cnt;
	logic             phase;

	// phase flips every half period, tick follows the new phase
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt       <= '0;
			phase     <= 1'b0;
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
		end else begin
			rise_tick <= 1'b0;
			fall_tick <= 1'b0;
			if (cnt == CNT_W'(`HPS_PS2_DIV)) begin
				cnt       <= '0;
				phase     <= ~phase;
				rise_tick <= ~phase;
				fall_tick <= phase;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// ==== source/input_regs.sv ====
module input_regs (
	input  logic               clk_sys,
	input  logic               reset,
	input  uio_pkg::uio_word_t host_word,
	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output logic [31:0]        joystick_0,
	output logic [31:0]        joystick_1,
	output logic [63:0]        status
);
	import uio_pkg::*;

	cfg_t cfg;

	// first word is the low half, anything after it the high half
	function automatic logic [31:0] joy_update(input logic [31:0] joy, input uio_word_t w);
		logic [31:0] next;
		next = joy;
		if (w.idx == 4'd1)
			next[15:0] = w.data;
		else
			next[31:16] = w.data;
		return next;
	endfunction

	assign buttons            = cfg.buttons;
	assign forced_scandoubler = cfg.forced_scandoubler;

	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (host_word.valid) begin
			case (host_word.cmd)
				CMD_CFG:  cfg <= cfg_t'(host_word.data);
				CMD_JOY0: joystick_0 <= joy_update(joystick_0, host_word);
				CMD_JOY1: joystick_1 <= joy_update(joystick_1, host_word);
				CMD_STATUS: begin
					// four slices, low first, extra words ignored
					case (host_word.idx)
						4'd1: status[15:0]  <= host_word.data;
						4'd2: status[31:16] <= host_word.data;
						4'd3: status[47:32] <= host_word.data;
						4'd4: status[63:48] <= host_word.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== source/uio_cmd_fsm.sv ====
`include "hps_link_settings.svh"

module uio_cmd_fsm (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	input  logic [2:0]             kbd_led_status,
	input  logic [2:0]             kbd_led_use,
	output logic [`HPS_WORD_W-1:0] io_dout,
	output uio_pkg::uio_word_t     host_word
);
	import uio_pkg::*;

	typedef enum logic [1:0] {IDLE, CMD, DATA} frame_state_e;

	frame_state_e           state;
	uio_cmd_e               cmd;
	logic [3:0]             word_cnt;
	logic                   skip;
	logic                   ps2_cmd;
	logic                   skip_word;
	logic [`HPS_WORD_W-1:0] led_word;

	logic                   word_valid;
	uio_cmd_e               word_cmd;
	logic [3:0]             word_idx;
	logic [`HPS_WORD_W-1:0] word_data;

	// 0xFF in the upper byte ends the useful part of a ps2 frame
	assign ps2_cmd   = (cmd == CMD_PS2_KBD) || (cmd == CMD_PS2_MOUSE);
	assign skip_word = ps2_cmd && (&io_din[`HPS_WORD_W-1:8]);

	// status/use pairs, led 2 first
	assign led_word = {{(`HPS_WORD_W-8){1'b0}}, 2'b01,
		kbd_led_status[2], kbd_led_use[2],
		kbd_led_status[1], kbd_led_use[1],
		kbd_led_status[0], kbd_led_use[0]};

	assign host_word = '{valid: word_valid, cmd: word_cmd, idx: word_idx, data: word_data};

	////////////////////
	// decoded word payload
	always_ff @(posedge clk_sys) begin
		if (io_strobe && (state == DATA)) begin
			word_cmd  <= cmd;
			word_idx  <= word_cnt;
			word_data <= io_din;
		end
	end

	////////////////////
	// frame control
	always_ff @(posedge clk_sys) begin
		if (reset || !io_enable) begin
			state      <= IDLE;
			cmd        <= uio_cmd_e'('0);
			word_cnt   <= '0;
			skip       <= 1'b0;
			word_valid <= 1'b0;
			io_dout    <= '0;
		end else begin
			word_valid <= 1'b0;
			case (state)
				IDLE, CMD: begin
					if (io_strobe) begin
						cmd      <= uio_cmd_e'(io_din);
						word_cnt <= 4'd1;
						io_dout  <= '0;
						state    <= DATA;
					end else begin
						state <= CMD;
					end
				end
				DATA: begin
					if (io_strobe) begin
						word_valid <= !(skip || skip_word);
						if (skip_word)
							skip <= 1'b1;
						// index saturates, later words share the last slot
						if (word_cnt != 4'd15)
							word_cnt <= word_cnt + 4'd1;
						io_dout <= (cmd == CMD_KBD_LED) ? led_word : '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== source/ps2_pkg.sv ====
package ps2_pkg;

	////////////////////
	// one ps2 port, both lines idle high
	typedef struct packed {
		logic clk;
		logic dat;
	} ps2_line_t;

	// device to host transmit sequence
	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} ps2_tx_state_e;

endpackage

// ==== source/uio_pkg.sv ====
`include "hps_link_settings.svh"

package uio_pkg;

	////////////////////
	// host command codes kept on this port
	typedef enum logic [15:0] {
		CMD_CFG       = 16'h0001,
		CMD_JOY0      = 16'h0002,
		CMD_JOY1      = 16'h0003,
		CMD_PS2_MOUSE = 16'h0004,
		CMD_PS2_KBD   = 16'h0005,
		CMD_STATUS    = 16'h001E,
		CMD_KBD_LED   = 16'h001F
	} uio_cmd_e;

	// one data word of a frame, after the command
	typedef struct packed {
		logic                   valid;
		uio_cmd_e               cmd;
		logic [3:0]             idx;
		logic [`HPS_WORD_W-1:0] data;
	} uio_word_t;

	////////////////////
	// config word layout
	typedef struct packed {
		logic [10:0] reserved_hi;
		logic        forced_scandoubler;
		logic [1:0]  reserved_lo;
		logic [1:0]  buttons;
	} cfg_t;

endpackage

// ==== source/hps_link_settings.svh ====
`ifndef HPS_LINK_SETTINGS_SVH
`define HPS_LINK_SETTINGS_SVH

////////////////////
// ps2 clock half period minus one, in clk_sys cycles
`define HPS_PS2_DIV 4

// ps2 byte queue depth as address bits
`define HPS_FIFO_BITS 3

// host port word
`define HPS_WORD_W 16

`endif
